// File: verilog.f
design/spi_pkg.sv
design/spi_clock_gen.sv
design/spi_shift_reg.sv
design/spi_regs.sv
design/spi_xip_fsm.sv
design/spi_apb_top.sv
verif/spi_flash_model.sv
verif/spi_apb_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SPI APB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module spi_apb_top_tb --Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

// File: verif/spi_apb_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_apb_top_tb;
  import spi_pkg::*;

  localparam int WAIT_LIMIT = 5000;

  logic       clock;
  logic       reset;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic [2:0] pprot;
  logic       pwrite;
  word_t      pwdata;
  strb_t      pstrb;
  logic       pready;
  word_t      prdata;
  logic       pslverr;
  logic       spi_sck;
  ss_t        spi_ss;
  logic       spi_mosi;
  logic       spi_miso;
  logic       spi_irq;

  int          error_count;
  int          timeout_count;
  logic [31:0] lcg_state;
  // Last 64 MOSI bits seen by the flash
  logic [63:0] mosi_bits;

  spi_apb_top spi_apb_top_inst (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pprot_i    (pprot),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .spi_irq_o  (spi_irq)
  );

  // Flash on select 0
  spi_flash_model flash_inst (
    .sck_i  (spi_sck),
    .ss_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  // 20 ns period
  always #10 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic apb_addr_t ctrl_addr(input reg_addr_t offset);
    return CTRL_BASE + 32'(offset);
  endfunction

  // Expected flash byte at a 24-bit address
  function automatic logic [7:0] flash_byte(input logic [23:0] addr);
    return (addr[7:0] ^ 8'hA5) + addr[23:16];
  endfunction

  // Four bytes, first one in the top lane
  function automatic word_t flash_word(input logic [23:0] addr);
    return {flash_byte(addr), flash_byte(addr + 24'd1),
            flash_byte(addr + 24'd2), flash_byte(addr + 24'd3)};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout while waiting for %s", what);
  endtask

  // Access phase until pready, then release the bus
  task automatic wait_for_ready(output word_t rdata, output logic err);
    int cycles;
    @(posedge clock);
    #1;
    penable = 1'b1;
    cycles  = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (!pready && cycles < WAIT_LIMIT);
    if (!pready) begin
      report_timeout("APB pready");
    end
    rdata   = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    // Idle cycle between transfers
    @(posedge clock);
    #1;
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data, input strb_t strb,
                           output logic err);
    word_t unused;
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    wait_for_ready(unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
    paddr   = addr;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = 4'h0;
    psel    = 1'b1;
    penable = 1'b0;
    wait_for_ready(data, err);
  endtask

  task automatic wait_for_irq();
    int cycles;
    cycles = 0;
    while (!spi_irq && cycles < WAIT_LIMIT) begin
      @(posedge clock);
      #1;
      cycles++;
    end
    if (!spi_irq) begin
      report_timeout("the transfer interrupt");
    end
  endtask

  // MOSI taken on rising SCK, as the flash does
  always @(posedge spi_sck) begin
    if (!spi_ss[0]) begin
      mosi_bits <= {mosi_bits[62:0], spi_mosi};
    end
  end

  // SCK must stay low while the flash is deselected
  always @(negedge clock) begin
    if (!reset && spi_ss[0]) begin
      check_value("sck idle while deselected", 64'd0, 64'(spi_sck));
    end
  end

  initial begin
    word_t       rd_data;
    logic        rd_err;
    word_t       rnd;
    word_t       ctrl_val;
    word_t       tx0_exp;
    logic [15:0] div_exp;
    ss_t         ss_exp;
    logic [23:0] flash_addr;
    apb_addr_t   xip_addr;
    int          i;

    clock         = 1'b0;
    reset         = 1'b1;
    paddr         = '0;
    psel          = 1'b0;
    penable       = 1'b0;
    pprot         = 3'b000;
    pwrite        = 1'b0;
    pwdata        = '0;
    pstrb         = 4'h0;
    error_count   = 0;
    timeout_count = 0;
    lcg_state     = 32'h65dd_6378;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    // Reset state
    check_value("reset ss", 64'hFF, 64'(spi_ss));
    check_value("reset sck", 64'd0, 64'(spi_sck));
    check_value("reset irq", 64'd0, 64'(spi_irq));
    apb_read(ctrl_addr(REG_CTRL), rd_data, rd_err);
    check_value("reset ctrl", 64'd0, 64'(rd_data));

    // Random register writes and readback
    rnd = lcg_next();
    div_exp = rnd[15:0];
    apb_write(ctrl_addr(REG_DIVIDER), rnd, 4'hF, rd_err);
    check_value("divider write pslverr", 64'd0, 64'(rd_err));
    apb_read(ctrl_addr(REG_DIVIDER), rd_data, rd_err);
    check_value("divider readback", 64'(div_exp), 64'(rd_data));
    rnd = lcg_next();
    ss_exp = rnd[SS_NUM-1:0];
    apb_write(ctrl_addr(REG_SS), rnd, 4'hF, rd_err);
    apb_read(ctrl_addr(REG_SS), rd_data, rd_err);
    check_value("ss readback", 64'(ss_exp), 64'(rd_data));
    // TX0 shows up later on MOSI behind the command word
    tx0_exp = lcg_next();
    apb_write(ctrl_addr(REG_RX0_TX0), tx0_exp, 4'hF, rd_err);
    check_value("tx0 write pslverr", 64'd0, 64'(rd_err));

    // Byte strobes: lane 1 only, then lanes above the divider
    rnd = lcg_next();
    div_exp[15:8] = rnd[15:8];
    apb_write(ctrl_addr(REG_DIVIDER), rnd, 4'b0010, rd_err);
    apb_read(ctrl_addr(REG_DIVIDER), rd_data, rd_err);
    check_value("divider lane 1 write", 64'(div_exp), 64'(rd_data));
    apb_write(ctrl_addr(REG_DIVIDER), lcg_next(), 4'b1100, rd_err);
    apb_read(ctrl_addr(REG_DIVIDER), rd_data, rd_err);
    check_value("divider upper lanes write", 64'(div_exp), 64'(rd_data));

    // Decode errors
    apb_read(ctrl_addr(5'h08), rd_data, rd_err);
    check_value("offset 08 read pslverr", 64'd1, 64'(rd_err));
    apb_write(ctrl_addr(5'h08), lcg_next(), 4'hF, rd_err);
    check_value("offset 08 write pslverr", 64'd1, 64'(rd_err));
    apb_read(32'h2000_0000, rd_data, rd_err);
    check_value("unmapped read pslverr", 64'd1, 64'(rd_err));
    // Low address bits alias DIVIDER and SS
    apb_write(32'h0000_0054, lcg_next(), 4'hF, rd_err);
    check_value("unmapped write pslverr", 64'd1, 64'(rd_err));
    apb_write(FLASH_BASE | 32'h0000_0118, lcg_next(), 4'hF, rd_err);
    check_value("flash write pslverr", 64'd1, 64'(rd_err));
    apb_read(32'h4000_0000, rd_data, rd_err);
    check_value("above flash pslverr", 64'd1, 64'(rd_err));
    apb_read(ctrl_addr(REG_DIVIDER), rd_data, rd_err);
    check_value("divider after errors", 64'(div_exp), 64'(rd_data));
    apb_read(ctrl_addr(REG_SS), rd_data, rd_err);
    check_value("ss after errors", 64'(ss_exp), 64'(rd_data));

    // Manual 64-bit read command through the registers
    rnd = lcg_next();
    flash_addr = rnd[23:0];
    ctrl_val = word_t'((1 << CTRL_GO_BIT) | (1 << CTRL_IE_BIT) | (1 << CTRL_ASS_BIT) | 64);
    apb_write(ctrl_addr(REG_RX1_TX1), {FLASH_READ_CMD, flash_addr}, 4'hF, rd_err);
    apb_write(ctrl_addr(REG_DIVIDER), 32'd3, 4'hF, rd_err);
    apb_write(ctrl_addr(REG_SS), 32'd1, 4'hF, rd_err);
    apb_write(ctrl_addr(REG_CTRL), ctrl_val, 4'hF, rd_err);
    wait_for_irq();
    check_value("ss after manual transfer", 64'hFF, 64'(spi_ss));
    check_value("manual transfer mosi", {8'h03, flash_addr, tx0_exp}, mosi_bits);
    // go_bsy cleared, the rest kept
    apb_read(ctrl_addr(REG_CTRL), rd_data, rd_err);
    check_value("ctrl after manual transfer", 64'(ctrl_val & ~word_t'(1 << CTRL_GO_BIT)),
                64'(rd_data));
    apb_read(ctrl_addr(REG_RX0_TX0), rd_data, rd_err);
    check_value("manual transfer data", 64'(flash_word(flash_addr)), 64'(rd_data));
    check_value("irq after read", 64'd0, 64'(spi_irq));

    // Execute-in-place reads
    for (i = 0; i < 8; i++) begin
      rnd = lcg_next();
      xip_addr = FLASH_BASE | (rnd & 32'h0FFF_FFFF);
      apb_read(xip_addr, rd_data, rd_err);
      check_value("xip read data", 64'(flash_word(xip_addr[23:0])), 64'(rd_data));
      check_value("xip read pslverr", 64'd0, 64'(rd_err));
      check_value("ss after xip read", 64'hFF, 64'(spi_ss));
      check_value("xip read mosi", {8'h03, xip_addr[23:0], tx0_exp}, mosi_bits);
    end

    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
  input  wire  sck_i,
  input  wire  ss_n_i,
  input  wire  mosi_i,
  output logic miso_o
);

  // Command byte and 24-bit address as shifted in
  logic [31:0] cmd_addr;
  logic [5:0]  in_cnt;
  // Data bits already sent
  logic [5:0]  out_cnt;
  logic [23:0] byte_addr;
  logic [7:0]  cur_byte;

  // Memory contents: scrambled low address byte plus the top address byte
  function automatic logic [7:0] mem_byte(input logic [23:0] addr);
    return (addr[7:0] ^ 8'hA5) + addr[23:16];
  endfunction

  // Byte now on the wire, address advances every 8 bits
  assign byte_addr = cmd_addr[23:0] + {21'b0, out_cnt[5:3]};
  assign cur_byte  = mem_byte(byte_addr);

  // Command and address sampled on rising SCK
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      cmd_addr <= '0;
      in_cnt   <= '0;
    end else if (in_cnt != 6'd32) begin
      cmd_addr <= {cmd_addr[30:0], mosi_i};
      in_cnt   <= in_cnt + 6'd1;
    end
  end

  // Read data launched on falling SCK, MSB of each byte first
  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      miso_o  <= 1'b0;
      out_cnt <= '0;
    end else if (in_cnt == 6'd32 && cmd_addr[31:24] == 8'h03) begin
      miso_o  <= cur_byte[3'd7 - out_cnt[2:0]];
      out_cnt <= out_cnt + 6'd1;
    end
  end

endmodule

`default_nettype wire

// File: design/spi_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_apb_top (
  input  wire                     clock,
  input  wire                     reset,
  input  wire spi_pkg::apb_addr_t paddr_i,
  input  wire                     psel_i,
  input  wire                     penable_i,
  input  wire [2:0]               pprot_i,
  input  wire                     pwrite_i,
  input  wire spi_pkg::word_t     pwdata_i,
  input  wire spi_pkg::strb_t     pstrb_i,
  output wire                     pready_o,
  output wire spi_pkg::word_t     prdata_o,
  output wire                     pslverr_o,
  output wire                     spi_sck_o,
  output wire spi_pkg::ss_t       spi_ss_o,
  output wire                     spi_mosi_o,
  input  wire                     spi_miso_i,
  output wire                     spi_irq_o
);
  import spi_pkg::*;

  // Register bus
  reg_addr_t reg_addr;
  word_t     reg_wdata;
  strb_t     reg_strb;
  logic      reg_we;
  logic      reg_stb;
  logic      reg_ack;
  word_t     reg_rdata;
  logic      reg_err;

  // Transfer control and data
  logic      start;
  div_t      divider;
  char_len_t char_len;
  shift_t    tx_data;
  shift_t    rx_data;
  logic      done;
  logic      rise_stb;
  logic      fall_stb;

  spi_xip_fsm u_xip_fsm (
    .clock       (clock),
    .reset       (reset),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_strb_o  (reg_strb),
    .reg_we_o    (reg_we),
    .reg_stb_o   (reg_stb),
    .reg_ack_i   (reg_ack),
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err)
  );

  spi_regs u_regs (
    .clock       (clock),
    .reset       (reset),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_strb_i  (reg_strb),
    .reg_we_i    (reg_we),
    .reg_stb_i   (reg_stb),
    .reg_ack_o   (reg_ack),
    .reg_rdata_o (reg_rdata),
    .reg_err_o   (reg_err),
    .start_o     (start),
    .divider_o   (divider),
    .char_len_o  (char_len),
    .tx_data_o   (tx_data),
    .rx_data_i   (rx_data),
    .done_i      (done),
    .ss_o        (spi_ss_o),
    .irq_o       (spi_irq_o)
  );

  // Done also parks the clock generator
  spi_clock_gen u_clock_gen (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .stop_i     (done),
    .divider_i  (divider),
    .sck_o      (spi_sck_o),
    .rise_stb_o (rise_stb),
    .fall_stb_o (fall_stb)
  );

  spi_shift_reg u_shift_reg (
    .clock      (clock),
    .reset      (reset),
    .start_i    (start),
    .rise_stb_i (rise_stb),
    .fall_stb_i (fall_stb),
    .char_len_i (char_len),
    .tx_data_i  (tx_data),
    .miso_i     (spi_miso_i),
    .mosi_o     (spi_mosi_o),
    .rx_data_o  (rx_data),
    .done_o     (done)
  );

endmodule

`default_nettype wire

// File: design/spi_xip_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_xip_fsm (
  input  wire                     clock,
  input  wire                     reset,
  input  wire spi_pkg::apb_addr_t paddr_i,
  input  wire                     psel_i,
  input  wire                     penable_i,
  input  wire                     pwrite_i,
  input  wire spi_pkg::word_t     pwdata_i,
  input  wire spi_pkg::strb_t     pstrb_i,
  output logic                    pready_o,
  output spi_pkg::word_t          prdata_o,
  output logic                    pslverr_o,
  output spi_pkg::reg_addr_t      reg_addr_o,
  output spi_pkg::word_t          reg_wdata_o,
  output spi_pkg::strb_t          reg_strb_o,
  output logic                    reg_we_o,
  output logic                    reg_stb_o,
  input  wire                     reg_ack_i,
  input  wire spi_pkg::word_t     reg_rdata_i,
  input  wire                     reg_err_i
);
  import spi_pkg::*;

  xip_state_t state;
  word_t      xip_cmd;
  logic       apb_req;
  logic       ctrl_hit;
  logic       flash_hit;
  logic       still_busy;

  // Access for the current sequence step
  reg_addr_t  seq_addr;
  word_t      seq_wdata;
  logic       seq_we;
  xip_state_t seq_next;

  assign apb_req   = psel_i && penable_i;
  assign ctrl_hit  = (paddr_i >= CTRL_BASE) && (paddr_i <= CTRL_LIMIT);
  assign flash_hit = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_LIMIT);

  // Poll answer with go_bsy still set
  assign still_busy = (state == WAIT_COMPLETE) && reg_rdata_i[CTRL_GO_BIT];

  always_comb begin
    seq_addr  = REG_RX0_TX0;
    seq_wdata = '0;
    seq_we    = 1'b0;
    seq_next  = IDLE;
    case (state)
      SEND_CMD: begin
        // Command and address go out first
        seq_addr  = REG_RX1_TX1;
        seq_wdata = xip_cmd;
        seq_we    = 1'b1;
        seq_next  = SET_DIVIDER;
      end
      SET_DIVIDER: begin
        seq_addr  = REG_DIVIDER;
        seq_wdata = XIP_DIVIDER;
        seq_we    = 1'b1;
        seq_next  = SET_SS;
      end
      SET_SS: begin
        // Flash sits on select 0
        seq_addr  = REG_SS;
        seq_wdata = word_t'(1);
        seq_we    = 1'b1;
        seq_next  = GO_BUSY;
      end
      GO_BUSY: begin
        seq_addr  = REG_CTRL;
        seq_wdata = XIP_CTRL_VALUE;
        seq_we    = 1'b1;
        seq_next  = WAIT_COMPLETE;
      end
      WAIT_COMPLETE: begin
        seq_addr = REG_CTRL;
        seq_next = READ_DATA;
      end
      READ_DATA: begin
        // Flash data ends up in the low word
        seq_addr = REG_RX0_TX0;
        seq_next = RESPOND;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= IDLE;
      xip_cmd     <= '0;
      reg_addr_o  <= '0;
      reg_wdata_o <= '0;
      reg_strb_o  <= '0;
      reg_we_o    <= 1'b0;
      reg_stb_o   <= 1'b0;
      pready_o    <= 1'b0;
      prdata_o    <= '0;
      pslverr_o   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (apb_req) begin
            if (ctrl_hit) begin
              // Forward once, READ_DATA waits for the answer
              reg_addr_o  <= paddr_i[4:0];
              reg_wdata_o <= pwdata_i;
              reg_strb_o  <= pstrb_i;
              reg_we_o    <= pwrite_i;
              reg_stb_o   <= 1'b1;
              state       <= READ_DATA;
            end else if (flash_hit && !pwrite_i) begin
              xip_cmd <= {FLASH_READ_CMD, paddr_i[23:0]};
              state   <= SEND_CMD;
            end else begin
              state <= REJECT;
            end
          end
        end
        SEND_CMD, SET_DIVIDER, SET_SS, GO_BUSY, WAIT_COMPLETE, READ_DATA: begin
          if (!reg_stb_o) begin
            // Issue the step after an idle bus cycle
            reg_addr_o  <= seq_addr;
            reg_wdata_o <= seq_wdata;
            reg_strb_o  <= seq_we ? 4'hF : 4'h0;
            reg_we_o    <= seq_we;
            reg_stb_o   <= 1'b1;
          end else if (reg_ack_i) begin
            reg_stb_o <= 1'b0;
            if (state == READ_DATA) begin
              pready_o  <= 1'b1;
              prdata_o  <= reg_rdata_i;
              pslverr_o <= reg_err_i;
            end
            // Busy poll repeats the CTRL read
            if (!still_busy) begin
              state <= seq_next;
            end
          end
        end
        REJECT: begin
          pready_o  <= 1'b1;
          pslverr_o <= 1'b1;
          prdata_o  <= '0;
          state     <= RESPOND;
        end
        RESPOND: begin
          // Single cycle pready, then wait for the master to let go
          pready_o  <= 1'b0;
          pslverr_o <= 1'b0;
          if (!psel_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_regs (
  input  wire                     clock,
  input  wire                     reset,
  input  wire spi_pkg::reg_addr_t reg_addr_i,
  input  wire spi_pkg::word_t     reg_wdata_i,
  input  wire spi_pkg::strb_t     reg_strb_i,
  input  wire                     reg_we_i,
  input  wire                     reg_stb_i,
  output logic                    reg_ack_o,
  output spi_pkg::word_t          reg_rdata_o,
  output logic                    reg_err_o,
  output logic                    start_o,
  output spi_pkg::div_t           divider_o,
  output spi_pkg::char_len_t      char_len_o,
  output spi_pkg::shift_t         tx_data_o,
  input  wire spi_pkg::shift_t    rx_data_i,
  input  wire                     done_i,
  output spi_pkg::ss_t            ss_o,
  output logic                    irq_o
);
  import spi_pkg::*;

  // Register storage
  word_t     tx0;
  word_t     tx1;
  shift_t    rx;
  char_len_t char_len;
  logic      go;
  logic      ie;
  logic      ass;
  div_t      divider;
  ss_t       ss;

  logic  access;
  logic  hit;
  word_t ctrl_word;
  word_t cur_word;
  word_t rd_word;
  word_t wmask;
  word_t wr_word;

  // New request only while no ack is pending
  assign access = reg_stb_i && !reg_ack_o;

  assign ctrl_word = {18'b0, ass, ie, 3'b0, go, 1'b0, char_len};

  // Byte lanes from the strobes
  assign wmask = {{8{reg_strb_i[3]}}, {8{reg_strb_i[2]}},
                  {8{reg_strb_i[1]}}, {8{reg_strb_i[0]}}};
  assign wr_word = (cur_word & ~wmask) | (reg_wdata_i & wmask);

  // Write view and read view differ only at the data offsets
  always_comb begin
    hit      = 1'b1;
    cur_word = '0;
    rd_word  = '0;
    case (reg_addr_i)
      REG_RX0_TX0: begin
        cur_word = tx0;
        rd_word  = rx[31:0];
      end
      REG_RX1_TX1: begin
        cur_word = tx1;
        rd_word  = rx[63:32];
      end
      REG_CTRL: begin
        cur_word = ctrl_word;
        rd_word  = ctrl_word;
      end
      REG_DIVIDER: begin
        cur_word = word_t'(divider);
        rd_word  = word_t'(divider);
      end
      REG_SS: begin
        cur_word = word_t'(ss);
        rd_word  = word_t'(ss);
      end
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      reg_ack_o   <= 1'b0;
      reg_err_o   <= 1'b0;
      reg_rdata_o <= '0;
      start_o     <= 1'b0;
      irq_o       <= 1'b0;
      tx0         <= '0;
      tx1         <= '0;
      rx          <= '0;
      char_len    <= '0;
      go          <= 1'b0;
      ie          <= 1'b0;
      ass         <= 1'b0;
      divider     <= '0;
      ss          <= '0;
    end else begin
      reg_ack_o   <= access;
      reg_err_o   <= access && !hit;
      reg_rdata_o <= rd_word;
      start_o     <= 1'b0;
      // Any access acknowledges the interrupt
      if (access) begin
        irq_o <= 1'b0;
      end
      if (access && reg_we_i && hit) begin
        case (reg_addr_i)
          REG_RX0_TX0: tx0 <= wr_word;
          REG_RX1_TX1: tx1 <= wr_word;
          REG_CTRL: begin
            // CTRL frozen while a transfer runs
            if (!go) begin
              char_len <= wr_word[6:0];
              ie       <= wr_word[CTRL_IE_BIT];
              ass      <= wr_word[CTRL_ASS_BIT];
              go       <= wr_word[CTRL_GO_BIT];
              start_o  <= wr_word[CTRL_GO_BIT];
            end
          end
          REG_DIVIDER: begin
            if (!go) begin
              divider <= wr_word[15:0];
            end
          end
          REG_SS: ss <= wr_word[SS_NUM-1:0];
          default: ;
        endcase
      end
      if (done_i) begin
        go <= 1'b0;
        rx <= rx_data_i;
        if (ie) begin
          irq_o <= 1'b1;
        end
      end
    end
  end

  assign divider_o  = divider;
  assign char_len_o = char_len;
  assign tx_data_o  = {tx1, tx0};

  // Active low selects, gated by busy in automatic mode
  assign ss_o = ass ? ~(ss & {SS_NUM{go}}) : ~ss;

endmodule

`default_nettype wire

// File: design/spi_shift_reg.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_reg (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     start_i,
  input  wire                     rise_stb_i,
  input  wire                     fall_stb_i,
  input  wire spi_pkg::char_len_t char_len_i,
  input  wire spi_pkg::shift_t    tx_data_i,
  input  wire                     miso_i,
  output logic                    mosi_o,
  output spi_pkg::shift_t         rx_data_o,
  output logic                    done_o
);
  import spi_pkg::*;

  shift_t    tx_shift;
  shift_t    rx_shift;
  char_len_t bit_cnt;
  char_len_t eff_len;
  logic      active;

  // Zero length means 64 bits, longer values clamp to 64
  always_comb begin
    if (char_len_i == '0 || char_len_i > 7'd64) begin
      eff_len = 7'd64;
    end else begin
      eff_len = char_len_i;
    end
  end

  // MSB first on the wire
  assign mosi_o = tx_shift[63];

  // Final falling edge closes the transfer
  assign done_o = active && fall_stb_i && (bit_cnt == '0);

  // Received bits land right-aligned
  assign rx_data_o = rx_shift;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx_shift <= '0;
      bit_cnt  <= '0;
      active   <= 1'b0;
    end else if (start_i) begin
      // Bit char_len-1 moves up to the MSB so it goes out first
      tx_shift <= tx_data_i << (7'd64 - eff_len);
      bit_cnt  <= eff_len;
      active   <= 1'b1;
    end else if (active) begin
      // One bit consumed per rising edge
      if (rise_stb_i) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
      if (fall_stb_i) begin
        if (bit_cnt == '0) begin
          active <= 1'b0;
        end else begin
          // Next bit on MOSI after the falling edge
          tx_shift <= tx_shift << 1;
        end
      end
    end
  end

  // MISO sampled on each rising edge
  always_ff @(posedge clock) begin
    if (start_i) begin
      rx_shift <= '0;
    end else if (active && rise_stb_i) begin
      rx_shift <= {rx_shift[62:0], miso_i};
    end
  end

endmodule

`default_nettype wire

// File: design/spi_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen (
  input  wire                clock,
  input  wire                reset,
  input  wire                start_i,
  input  wire                stop_i,
  input  wire spi_pkg::div_t divider_i,
  output logic               sck_o,
  output logic               rise_stb_o,
  output logic               fall_stb_o
);
  import spi_pkg::*;

  // Half period counter
  div_t cnt;
  logic running;
  logic tick;

  // Wrap of the counter marks an SCK toggle
  assign tick = running && (cnt == '0);

  // Toggle direction taken from the current SCK level
  assign rise_stb_o = tick && !sck_o;
  assign fall_stb_o = tick && sck_o;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      running <= 1'b0;
      cnt     <= '0;
      sck_o   <= 1'b0;
    end else if (stop_i) begin
      // End of transfer parks SCK low
      running <= 1'b0;
      sck_o   <= 1'b0;
    end else if (start_i) begin
      // Arm with a full half period before the first edge
      running <= 1'b1;
      cnt     <= divider_i;
      sck_o   <= 1'b0;
    end else if (running) begin
      if (cnt == '0) begin
        // Reload for the next half period
        cnt   <= divider_i;
        sck_o <= !sck_o;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Number of slave select lines
  localparam int SS_NUM = 8;

  // Bus and datapath widths
  typedef logic [31:0]       apb_addr_t;
  typedef logic [31:0]       word_t;
  typedef logic [4:0]        reg_addr_t;
  typedef logic [3:0]        strb_t;
  typedef logic [15:0]       div_t;
  typedef logic [6:0]        char_len_t;
  typedef logic [SS_NUM-1:0] ss_t;
  typedef logic [63:0]       shift_t;

  // Flash window for execute-in-place reads
  localparam apb_addr_t FLASH_BASE  = 32'h3000_0000;
  localparam apb_addr_t FLASH_LIMIT = 32'h3FFF_FFFF;
  // Register window of the SPI master
  localparam apb_addr_t CTRL_BASE   = 32'h1000_1000;
  localparam apb_addr_t CTRL_LIMIT  = 32'h1000_1FFF;

  // Register offsets
  localparam reg_addr_t REG_RX0_TX0 = 5'h00;
  localparam reg_addr_t REG_RX1_TX1 = 5'h04;
  localparam reg_addr_t REG_CTRL    = 5'h10;
  localparam reg_addr_t REG_DIVIDER = 5'h14;
  localparam reg_addr_t REG_SS      = 5'h18;

  // CTRL bit positions
  localparam int CTRL_GO_BIT  = 8;
  localparam int CTRL_IE_BIT  = 12;
  localparam int CTRL_ASS_BIT = 13;

  // Flash read sequence constants
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;
  localparam word_t      XIP_DIVIDER    = 32'd1;
  // go_bsy and ass set, char_len of 64 bits
  localparam word_t      XIP_CTRL_VALUE =
    word_t'((1 << CTRL_GO_BIT) | (1 << CTRL_ASS_BIT) | 64);

  // Flash read sequencer states
  typedef enum logic [3:0] {
    IDLE,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_COMPLETE,
    READ_DATA,
    RESPOND,
    REJECT
  } xip_state_t;

endpackage

`default_nettype wire
